// ==== sprite_pkg.sv ====
package sprite_pkg;

  // Horizontal timing in pixel clocks.
  localparam int h_display = 256;
  localparam int h_back    = 23;
  localparam int h_front   = 7;
  localparam int h_sync    = 23;

  // Vertical timing in lines.
  localparam int v_display = 240;
  localparam int v_back    = 5;
  localparam int v_front   = 14;
  localparam int v_sync    = 3;

  // Beam and sprite coordinates share one width.
  localparam int pos_width = 9;

  // Sprite edge length in pixels, both directions.
  localparam int sprite_size = 16;

  // Host register map.
  localparam logic [1:0] addr_x    = 2'd0;
  localparam logic [1:0] addr_y    = 2'd1;
  localparam logic [1:0] addr_attr = 2'd2;

  // Values after reset let a sprite show before the host writes anything.
  localparam logic [pos_width-1:0] reset_x     = 9'd128;
  localparam logic [pos_width-1:0] reset_y     = 9'd128;
  localparam logic [2:0]           reset_color = 3'b111;

endpackage

// ==== hvsync_generator.sv ====
module hvsync_generator #(
  parameter int h_display = sprite_pkg::h_display,
  parameter int h_back    = sprite_pkg::h_back,
  parameter int h_front   = sprite_pkg::h_front,
  parameter int h_sync    = sprite_pkg::h_sync,
  parameter int v_display = sprite_pkg::v_display,
  parameter int v_back    = sprite_pkg::v_back,
  parameter int v_front   = sprite_pkg::v_front,
  parameter int v_sync    = sprite_pkg::v_sync
) (
  input  logic                           clk,
  input  logic                           rst_n,
  output logic                           hsync,
  output logic                           vsync,
  output logic                           display_on,
  output logic [sprite_pkg::pos_width-1:0] hpos,
  output logic [sprite_pkg::pos_width-1:0] vpos
);

  localparam int pw = sprite_pkg::pos_width;

  localparam int h_total = h_display + h_back + h_front + h_sync;
  localparam int v_total = v_display + v_back + v_front + v_sync;

  // A line is display, back porch, sync, front porch.
  localparam int h_sync_first_i = h_display + h_back;
  localparam int h_sync_last_i  = h_sync_first_i + h_sync - 1;

  // Vertical sync closes the frame, after both porches.
  localparam int v_sync_first_i = v_display + v_back + v_front;
  localparam int v_sync_last_i  = v_sync_first_i + v_sync - 1;

  localparam int h_max_i = h_total - 1;
  localparam int v_max_i = v_total - 1;

  localparam logic [pw-1:0] h_max        = h_max_i[pw-1:0];
  localparam logic [pw-1:0] v_max        = v_max_i[pw-1:0];
  localparam logic [pw-1:0] h_end        = h_display[pw-1:0];
  localparam logic [pw-1:0] v_end        = v_display[pw-1:0];
  localparam logic [pw-1:0] h_sync_first = h_sync_first_i[pw-1:0];
  localparam logic [pw-1:0] h_sync_last  = h_sync_last_i[pw-1:0];
  localparam logic [pw-1:0] v_sync_first = v_sync_first_i[pw-1:0];
  localparam logic [pw-1:0] v_sync_last  = v_sync_last_i[pw-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hpos <= '0;
      vpos <= '0;
    end else if (hpos == h_max) begin
      hpos <= '0;
      if (vpos == v_max) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 1'b1;
      end
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  // Decoded straight from the counters so they line up with hpos and vpos.
  assign hsync      = (hpos >= h_sync_first) && (hpos <= h_sync_last);
  assign vsync      = (vpos >= v_sync_first) && (vpos <= v_sync_last);
  assign display_on = (hpos < h_end) && (vpos < v_end);

  counters_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    (hpos <= h_max) && (vpos <= v_max)
  );

endmodule

// ==== car_bitmap.sv ====
module car_bitmap (
  input  logic [3:0] row,
  output logic [7:0] bits
);

  // Left half of the car; the renderer mirrors it for the right half.
  always_comb begin
    case (row)
      4'd0:    bits = 8'b00000000;
      4'd1:    bits = 8'b00101110;
      4'd2:    bits = 8'b11101110;
      4'd3:    bits = 8'b11111110;
      4'd4:    bits = 8'b11101110;
      4'd5:    bits = 8'b01101110;
      4'd6:    bits = 8'b00110000;
      4'd7:    bits = 8'b00110000;
      4'd8:    bits = 8'b00110000;
      4'd9:    bits = 8'b01110000;
      4'd10:   bits = 8'b01100000;
      4'd11:   bits = 8'b11100000;
      4'd12:   bits = 8'b11101100;
      4'd13:   bits = 8'b11111100;
      4'd14:   bits = 8'b11001100;
      default: bits = 8'b00001100;
    endcase
  end

endmodule

// ==== sprite_regs.sv ====
module sprite_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wr_en,
  input  logic [1:0]                       wr_addr,
  input  logic [sprite_pkg::pos_width-1:0] wr_data,
  input  logic [sprite_pkg::pos_width-1:0] hpos,
  input  logic [sprite_pkg::pos_width-1:0] vpos,
  output logic [sprite_pkg::pos_width-1:0] active_x,
  output logic [sprite_pkg::pos_width-1:0] active_y,
  output logic [2:0]                       active_color,
  output logic                             active_enable
);

  logic [sprite_pkg::pos_width-1:0] pend_x;
  logic [sprite_pkg::pos_width-1:0] pend_y;
  logic [2:0]                       pend_color;
  logic                             pend_enable;
  logic [sprite_pkg::pos_width-1:0] act_x;
  logic [sprite_pkg::pos_width-1:0] act_y;
  logic [2:0]                       act_color;
  logic                             act_enable;
  logic                             frame_start;

  assign frame_start = (hpos == '0) && (vpos == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_x      <= sprite_pkg::reset_x;
      pend_y      <= sprite_pkg::reset_y;
      pend_color  <= sprite_pkg::reset_color;
      pend_enable <= 1'b1;
      act_x       <= sprite_pkg::reset_x;
      act_y       <= sprite_pkg::reset_y;
      act_color   <= sprite_pkg::reset_color;
      act_enable  <= 1'b1;
    end else begin
      if (wr_en) begin
        case (wr_addr)
          sprite_pkg::addr_x: pend_x <= wr_data;
          sprite_pkg::addr_y: pend_y <= wr_data;
          sprite_pkg::addr_attr: begin
            // Colour in bits 2:0, enable in bit 3.
            pend_color  <= wr_data[2:0];
            pend_enable <= wr_data[3];
          end
          default: ;
        endcase
      end
      // Old pending set is taken here. A write in this cycle waits a frame.
      if (frame_start) begin
        act_x      <= pend_x;
        act_y      <= pend_y;
        act_color  <= pend_color;
        act_enable <= pend_enable;
      end
    end
  end

  // Forward the new set during the frame start cycle so pixel 0,0 uses it too.
  assign active_x      = frame_start ? pend_x      : act_x;
  assign active_y      = frame_start ? pend_y      : act_y;
  assign active_color  = frame_start ? pend_color  : act_color;
  assign active_enable = frame_start ? pend_enable : act_enable;

  no_illegal_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> (wr_addr != 2'd3)
  );

endmodule

// ==== sprite_renderer.sv ====
module sprite_renderer #(
  parameter int h_display = sprite_pkg::h_display,
  parameter int v_display = sprite_pkg::v_display
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [sprite_pkg::pos_width-1:0] hpos,
  input  logic [sprite_pkg::pos_width-1:0] vpos,
  input  logic                             display_on,
  input  logic                             hsync,
  input  logic                             vsync,
  input  logic [sprite_pkg::pos_width-1:0] active_x,
  input  logic [sprite_pkg::pos_width-1:0] active_y,
  input  logic [2:0]                       active_color,
  input  logic                             active_enable,
  input  logic [7:0]                       bits,
  output logic [3:0]                       row,
  output logic [2:0]                       rgb,
  output logic [sprite_pkg::pos_width-1:0] hpos_out,
  output logic [sprite_pkg::pos_width-1:0] vpos_out,
  output logic                             display_on_out,
  output logic                             hsync_out,
  output logic                             vsync_out
);

  localparam int pw         = sprite_pkg::pos_width;
  localparam int last_ofs_i = sprite_pkg::sprite_size - 1;

  localparam logic [3:0]    last_ofs = last_ofs_i[3:0];
  localparam logic [pw-1:0] h_end    = h_display[pw-1:0];
  localparam logic [pw-1:0] v_end    = v_display[pw-1:0];

  logic          x_run_q;
  logic [3:0]    x_cnt_q;
  logic          y_run_q;
  logic [3:0]    y_cnt_q;
  logic          x_hit;
  logic          x_run;
  logic [3:0]    x_cnt;
  logic          line_start;
  logic          v_hit;
  logic          y_step_run;
  logic [3:0]    y_step_cnt;
  logic          y_run;
  logic [3:0]    y_cnt;
  logic [2:0]    bit_idx;
  logic          pixel_on;
  logic [pw-1:0] col_dist;

  // Column counter starts on the exact beam position, so the hit is used in the same cycle.
  always_comb begin
    x_hit = (hpos == active_x) && (hpos < h_end);
    x_run = x_hit || (x_run_q && (hpos < h_end));
    x_cnt = x_hit ? 4'd0 : x_cnt_q;
  end

  // Row counter steps once per line at hpos 0.
  always_comb begin
    line_start = (hpos == '0);
    v_hit      = (vpos == active_y) && (vpos < v_end);
    y_step_run = v_hit || (y_run_q && (y_cnt_q != last_ofs) && (vpos < v_end));
    y_step_cnt = v_hit ? 4'd0 : y_cnt_q + 4'd1;
    y_run      = line_start ? y_step_run : y_run_q;
    y_cnt      = line_start ? y_step_cnt : y_cnt_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_run_q <= 1'b0;
      x_cnt_q <= '0;
      y_run_q <= 1'b0;
      y_cnt_q <= '0;
    end else begin
      x_run_q <= x_run && (x_cnt != last_ofs);
      x_cnt_q <= x_cnt + 4'd1;
      if (line_start) begin
        y_run_q <= y_step_run;
        y_cnt_q <= y_step_cnt;
      end
    end
  end

  assign row = y_cnt;

  // Columns 0..7 read the bitmap from bit 7 down, 8..15 read it back up.
  assign bit_idx  = x_cnt[3] ? x_cnt[2:0] : ~x_cnt[2:0];
  assign pixel_on = display_on && active_enable && x_run && y_run && bits[bit_idx];

  // One register stage keeps beam signals and colour aligned.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rgb            <= 3'b000;
      hpos_out       <= '0;
      vpos_out       <= '0;
      display_on_out <= 1'b0;
      hsync_out      <= 1'b0;
      vsync_out      <= 1'b0;
    end else begin
      rgb            <= pixel_on ? active_color : 3'b000;
      hpos_out       <= hpos;
      vpos_out       <= vpos;
      display_on_out <= display_on;
      hsync_out      <= hsync;
      vsync_out      <= vsync;
    end
  end

  // distance of the beam from the sprite's left edge
  assign col_dist = hpos - active_x;

  col_in_sprite: assert property (
    @(posedge clk) disable iff (!rst_n)
    x_run |-> (col_dist < sprite_pkg::sprite_size)
  );

endmodule

// ==== sprite_video_top.sv ====
module sprite_video_top #(
  parameter int h_display = sprite_pkg::h_display,
  parameter int h_back    = sprite_pkg::h_back,
  parameter int h_front   = sprite_pkg::h_front,
  parameter int h_sync    = sprite_pkg::h_sync,
  parameter int v_display = sprite_pkg::v_display,
  parameter int v_back    = sprite_pkg::v_back,
  parameter int v_front   = sprite_pkg::v_front,
  parameter int v_sync    = sprite_pkg::v_sync
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wr_en,
  input  logic [1:0]                       wr_addr,
  input  logic [sprite_pkg::pos_width-1:0] wr_data,
  output logic                             hsync,
  output logic                             vsync,
  output logic                             display_on,
  output logic [sprite_pkg::pos_width-1:0] hpos,
  output logic [sprite_pkg::pos_width-1:0] vpos,
  output logic [2:0]                       rgb
);

  logic                             gen_hsync;
  logic                             gen_vsync;
  logic                             gen_display_on;
  logic [sprite_pkg::pos_width-1:0] gen_hpos;
  logic [sprite_pkg::pos_width-1:0] gen_vpos;
  logic [sprite_pkg::pos_width-1:0] active_x;
  logic [sprite_pkg::pos_width-1:0] active_y;
  logic [2:0]                       active_color;
  logic                             active_enable;
  logic [3:0]                       row;
  logic [7:0]                       bits;

  hvsync_generator #(
    .h_display(h_display),
    .h_back   (h_back),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .v_display(v_display),
    .v_back   (v_back),
    .v_front  (v_front),
    .v_sync   (v_sync)
  ) u_hvsync (
    .clk       (clk),
    .rst_n     (rst_n),
    .hsync     (gen_hsync),
    .vsync     (gen_vsync),
    .display_on(gen_display_on),
    .hpos      (gen_hpos),
    .vpos      (gen_vpos)
  );

  sprite_regs u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .hpos         (gen_hpos),
    .vpos         (gen_vpos),
    .active_x     (active_x),
    .active_y     (active_y),
    .active_color (active_color),
    .active_enable(active_enable)
  );

  car_bitmap u_bitmap (
    .row (row),
    .bits(bits)
  );

  // All outputs leave through the renderer's aligned stage.
  sprite_renderer #(
    .h_display(h_display),
    .v_display(v_display)
  ) u_renderer (
    .clk           (clk),
    .rst_n         (rst_n),
    .hpos          (gen_hpos),
    .vpos          (gen_vpos),
    .display_on    (gen_display_on),
    .hsync         (gen_hsync),
    .vsync         (gen_vsync),
    .active_x      (active_x),
    .active_y      (active_y),
    .active_color  (active_color),
    .active_enable (active_enable),
    .bits          (bits),
    .row           (row),
    .rgb           (rgb),
    .hpos_out      (hpos),
    .vpos_out      (vpos),
    .display_on_out(display_on),
    .hsync_out     (hsync),
    .vsync_out     (vsync)
  );

endmodule

// ==== tb_sprite_video.sv ====
module tb_sprite_video;

  timeunit 1ns;
  timeprecision 100ps;

  // Raster geometry as seen at the DUT outputs.
  localparam int line_len     = 309;
  localparam int frame_lines  = 262;
  localparam int frame_cycles = line_len * frame_lines;
  localparam int disp_w       = 256;
  localparam int disp_h       = 240;
  localparam int hs_first     = 279;
  localparam int hs_last      = 301;
  localparam int vs_first     = 259;
  localparam int vs_last      = 261;

  logic       clk;
  logic       rst_n;
  logic       wr_en;
  logic [1:0] wr_addr;
  logic [8:0] wr_data;
  logic       hsync;
  logic       vsync;
  logic       display_on;
  logic [8:0] hpos;
  logic [8:0] vpos;
  logic [2:0] rgb;

  // Case table with one entry per queue index.
  string case_name[$];
  int    case_x[$];
  int    case_y[$];
  int    case_color[$];
  int    case_en[$];
  int    case_lit[$];

  logic [7:0] ref_rows[16];
  string      cur_name;
  integer     seed;
  int         cycle_count;
  int         cycle_limit;

  sprite_video_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .hsync     (hsync),
    .vsync     (vsync),
    .display_on(display_on),
    .hpos      (hpos),
    .vpos      (vpos),
    .rgb       (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run took more cycles than the test length allows.");
      $display("Regression failed");
      $fatal(1, "timeout after %0d cycles", cycle_count);
    end
  end

  task automatic report_value(input string what, input int expected, input int actual);
    $display("[ERROR] %s %s: expected %0d, actual %0d", cur_name, what, expected, actual);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic add_case(input string name, input int x, input int y, input int color,
                          input int en, input int lit);
    case_name.push_back(name);
    case_x.push_back(x);
    case_y.push_back(y);
    case_color.push_back(color);
    case_en.push_back(en);
    case_lit.push_back(lit);
  endtask

  // Pixel rule with the right half mirrored and no wraparound.
  function automatic int expected_rgb(input int h, input int v, input int x, input int y,
                                      input int color, input int en);
    int c;
    int r;
    int idx;
    c = h - x;
    r = v - y;
    if (h >= disp_w || v >= disp_h || en == 0) return 0;
    if (c < 0 || c > 15 || r < 0 || r > 15) return 0;
    if (c < 8) begin
      idx = 7 - c;
    end else begin
      idx = c - 8;
    end
    return ref_rows[r][idx] ? color : 0;
  endfunction

  function automatic int count_lit(input int x, input int y, input int en);
    int total;
    total = 0;
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < 16; c++) begin
        if (en != 0 && x + c < disp_w && y + r < disp_h &&
            ref_rows[r][(c < 8) ? 7 - c : c - 8]) begin
          total++;
        end
      end
    end
    return total;
  endfunction

  // Sync and display windows are checked on every sampled cycle.
  task automatic check_beam();
    int exp_hs;
    int exp_vs;
    int exp_de;
    exp_hs = (hpos >= hs_first && hpos <= hs_last) ? 1 : 0;
    exp_vs = (vpos >= vs_first && vpos <= vs_last) ? 1 : 0;
    exp_de = (hpos < disp_w && vpos < disp_h) ? 1 : 0;
    assert (hsync === exp_hs[0])
      else report_value($sformatf("hsync at %0d,%0d", hpos, vpos), exp_hs, int'(hsync));
    assert (vsync === exp_vs[0])
      else report_value($sformatf("vsync at %0d,%0d", hpos, vpos), exp_vs, int'(vsync));
    assert (display_on === exp_de[0])
      else report_value($sformatf("display_on at %0d,%0d", hpos, vpos), exp_de,
                        int'(display_on));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    check_beam();
  endtask

  task automatic write_reg(input logic [1:0] addr, input int data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data[8:0];
    next_cycle();
    wr_en   = 1'b0;
  endtask

  task automatic wait_origin(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      next_cycle();
      if (hpos == 9'd0 && vpos == 9'd0) seen++;
    end
  endtask

  // Starts on output position 0,0 and ends on the last pixel of the frame.
  task automatic scan_frame(input int x, input int y, input int color, input int en,
                            input bit mid_write, input int nx, input int ny, input int nattr,
                            output int lit);
    int write_at;
    int exp_rgb;
    write_at = 120 * line_len + 40;
    lit = 0;
    for (int i = 0; i < frame_cycles; i++) begin
      if (i > 0) next_cycle();
      assert (hpos === 9'(i % line_len))
        else report_value("hpos in frame scan", i % line_len, int'(hpos));
      assert (vpos === 9'(i / line_len))
        else report_value("vpos in frame scan", i / line_len, int'(vpos));
      if (mid_write) begin
        wr_en   = (i >= write_at && i < write_at + 3);
        wr_addr = 2'(i - write_at);
        if (i == write_at) wr_data = nx[8:0];
        if (i == write_at + 1) wr_data = ny[8:0];
        if (i == write_at + 2) wr_data = nattr[8:0];
      end
      exp_rgb = expected_rgb(int'(hpos), int'(vpos), x, y, color, en);
      assert (rgb === exp_rgb[2:0])
        else report_value($sformatf("rgb at %0d,%0d", hpos, vpos), exp_rgb, int'(rgb));
      if (rgb != 3'b000) lit++;
    end
    wr_en = 1'b0;
  endtask

  task automatic check_lit(input int x, input int y, input int en, input int seen);
    int expected;
    expected = count_lit(x, y, en);
    assert (seen == expected) else report_value("lit pixel count", expected, seen);
  endtask

  initial begin
    int lit;
    rst_n       = 1'b0;
    wr_en       = 1'b0;
    wr_addr     = 2'd0;
    wr_data     = 9'd0;
    cycle_limit = 0;
    seed        = 51702;
    cur_name    = "reset";

    ref_rows[0]  = 8'b00000000;
    ref_rows[1]  = 8'b00101110;
    ref_rows[2]  = 8'b11101110;
    ref_rows[3]  = 8'b11111110;
    ref_rows[4]  = 8'b11101110;
    ref_rows[5]  = 8'b01101110;
    ref_rows[6]  = 8'b00110000;
    ref_rows[7]  = 8'b00110000;
    ref_rows[8]  = 8'b00110000;
    ref_rows[9]  = 8'b01110000;
    ref_rows[10] = 8'b01100000;
    ref_rows[11] = 8'b11100000;
    ref_rows[12] = 8'b11101100;
    ref_rows[13] = 8'b11111100;
    ref_rows[14] = 8'b11001100;
    ref_rows[15] = 8'b00001100;

    add_case("centre",      120, 100, 2, 1, 118);
    add_case("origin",        0,   0, 5, 1, 118);
    add_case("disabled",    120, 100, 7, 0,   0);
    add_case("clip_right",  250, 100, 6, 1,  54);
    add_case("clip_bottom",  60, 235, 1, 1,  46);
    add_case("clip_corner", 250, 235, 3, 1,  19);
    // A negative count means the reference computes it alone.
    add_case("random", $unsigned($random(seed)) % disp_w,
             $unsigned($random(seed)) % disp_h, 4, 1, -1);
    cycle_limit = (case_name.size() + 2) * 3 * frame_cycles;

    repeat (4) @(posedge clk);
    #1;
    assert (hsync === 1'b0 && vsync === 1'b0 && display_on === 1'b0 && rgb === 3'b000 &&
            hpos === 9'd0 && vpos === 9'd0)
      else report_value("outputs in reset", 0,
                        int'({hsync, vsync, display_on, rgb, hpos, vpos}));
    rst_n = 1'b1;

    // Reset sprite, before any write.
    wait_origin(1);
    scan_frame(128, 128, 7, 1, 1'b0, 0, 0, 0, lit);
    check_lit(128, 128, 1, lit);

    for (int i = 0; i < case_name.size(); i++) begin
      cur_name = case_name[i];
      if (case_lit[i] >= 0) begin
        assert (count_lit(case_x[i], case_y[i], case_en[i]) == case_lit[i])
          else report_value("table lit count", case_lit[i],
                            count_lit(case_x[i], case_y[i], case_en[i]));
      end
      write_reg(2'd0, case_x[i]);
      write_reg(2'd1, case_y[i]);
      write_reg(2'd2, case_en[i] * 8 + case_color[i]);
      wait_origin(2);
      scan_frame(case_x[i], case_y[i], case_color[i], case_en[i], 1'b0, 0, 0, 0, lit);
      check_lit(case_x[i], case_y[i], case_en[i], lit);
    end

    // New values written in mid-frame show only from the following frame.
    cur_name = "mid_frame";
    write_reg(2'd0, 100);
    write_reg(2'd1, 180);
    write_reg(2'd2, 8 + 3);
    wait_origin(2);
    scan_frame(100, 180, 3, 1, 1'b1, 30, 150, 8 + 5, lit);
    check_lit(100, 180, 1, lit);
    next_cycle();
    scan_frame(30, 150, 5, 1, 1'b0, 0, 0, 0, lit);
    check_lit(30, 150, 1, lit);

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== list.f ====
sprite_pkg.sv
hvsync_generator.sv
car_bitmap.sv
sprite_regs.sv
sprite_renderer.sv
sprite_video_top.sv
tb_sprite_video.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the project with Verilator and run the testbench.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sprite_video \
  -f list.f \
  -o sim_sprite_video &&
./obj_dir/sim_sprite_video ||
exit 1
